// ==== Makefile ====
# Verilator flow for the Sv39 data MMU

VERILATOR ?= verilator
FILELIST  ?= list.f
TB_TOP    ?= tb_mmu
RTL_TOP   ?= mmu_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
RTL_FILES ?= $(filter design/%,$(shell cat $(FILELIST)))

.PHONY: all lint sim clean

all: sim

# RTL on its own, then the whole project with the testbench on top
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_FILES)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

# a failing run ends in $$fatal, so the binary returns a nonzero status
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== design/dtlb.sv ====
// Data TLB
// fully associative, holds 4K, 2M and 1G translations
// lookup is combinational, refills land in a round-robin slot,
// a flush drops every entry

`timescale 1ns/1ps

module dtlb (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 flush_i,
  input  mmu_pkg::tlb_update_t update_i,
  input  mmu_pkg::vaddr_t      lu_vaddr_i,
  output mmu_pkg::tlb_lookup_t lu_o
);

  typedef struct packed {
    logic          is_2m;
    logic          is_1g;
    mmu_pkg::vpn_t vpn;
  } tlb_tag_t;

  tlb_tag_t      [mmu_pkg::DTLB_ENTRIES-1:0] tag_q;
  mmu_pkg::pte_t [mmu_pkg::DTLB_ENTRIES-1:0] pte_q;
  logic          [mmu_pkg::DTLB_ENTRIES-1:0] valid_q;
  logic          [mmu_pkg::DTLB_ENTRIES-1:0] match;
  logic [$clog2(mmu_pkg::DTLB_ENTRIES)-1:0]  victim_q;

  logic [mmu_pkg::VPN_W-1:0] lu_vpn2;
  logic [mmu_pkg::VPN_W-1:0] lu_vpn1;
  logic [mmu_pkg::VPN_W-1:0] lu_vpn0;

  assign lu_vpn2 = lu_vaddr_i[mmu_pkg::PAGE_OFFSET_W + 2*mmu_pkg::VPN_W +: mmu_pkg::VPN_W];
  assign lu_vpn1 = lu_vaddr_i[mmu_pkg::PAGE_OFFSET_W + mmu_pkg::VPN_W +: mmu_pkg::VPN_W];
  assign lu_vpn0 = lu_vaddr_i[mmu_pkg::PAGE_OFFSET_W +: mmu_pkg::VPN_W];

  // --------------------
  // tag compare
  // --------------------
  // superpages ignore the lower VPN slices
  for (genvar i = 0; i < mmu_pkg::DTLB_ENTRIES; i++) begin : g_match
    logic vpn2_eq;
    logic vpn1_eq;
    logic vpn0_eq;

    assign vpn2_eq = tag_q[i].vpn[2*mmu_pkg::VPN_W +: mmu_pkg::VPN_W] == lu_vpn2;
    assign vpn1_eq = tag_q[i].vpn[mmu_pkg::VPN_W +: mmu_pkg::VPN_W] == lu_vpn1;
    assign vpn0_eq = tag_q[i].vpn[0 +: mmu_pkg::VPN_W] == lu_vpn0;

    assign match[i] = valid_q[i] && vpn2_eq
                   && (tag_q[i].is_1g || vpn1_eq)
                   && (tag_q[i].is_1g || tag_q[i].is_2m || vpn0_eq);
  end

  // at most one entry matches, the walker only refills on a miss
  always_comb begin
    lu_o = '0;
    for (int i = 0; i < mmu_pkg::DTLB_ENTRIES; i++) begin
      if (match[i]) begin
        lu_o.hit   = 1'b1;
        lu_o.is_2m = tag_q[i].is_2m;
        lu_o.is_1g = tag_q[i].is_1g;
        lu_o.pte   = pte_q[i];
      end
    end
  end

  // --------------------
  // refill and flush
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q  <= '0;
      victim_q <= '0;
    end else if (flush_i) begin
      // flush wins over a refill in the same cycle
      valid_q <= '0;
    end else if (update_i.valid) begin
      valid_q[victim_q] <= 1'b1;
      if (int'(victim_q) == mmu_pkg::DTLB_ENTRIES - 1) begin
        victim_q <= '0;
      end else begin
        victim_q <= victim_q + 1'b1;
      end
    end
  end

  // tags and PTEs are only read behind a valid bit
  always_ff @(posedge clk_i) begin
    if (update_i.valid) begin
      tag_q[victim_q].is_2m <= update_i.is_2m;
      tag_q[victim_q].is_1g <= update_i.is_1g;
      tag_q[victim_q].vpn   <= update_i.vpn;
      pte_q[victim_q]       <= update_i.pte;
    end
  end

endmodule

// ==== design/ld_st_translate.sv ====
// Load/store address translation stage
// registers the request and the TLB answer, forms the physical
// address one cycle later and checks user, SUM, write and dirty rules;
// misses start a table walk and end on refill or walk fault

`timescale 1ns/1ps

module ld_st_translate (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    lsu_req_i,
  input  mmu_pkg::vaddr_t         lsu_vaddr_i,
  input  logic                    lsu_is_store_i,
  input  logic                    en_i,
  input  mmu_pkg::priv_lvl_t      priv_lvl_i,
  input  logic                    sum_i,
  input  mmu_pkg::tlb_lookup_t    lookup_i,
  input  logic                    ptw_active_i,
  input  logic                    ptw_error_i,
  input  mmu_pkg::vaddr_t         walk_err_vaddr_i,
  output logic                    walk_req_o,
  output mmu_pkg::vaddr_t         walk_vaddr_o,
  output logic                    dtlb_hit_o,
  output logic                    valid_o,
  output mmu_pkg::paddr_t         paddr_o,
  output mmu_pkg::lsu_exception_t exception_o
);

  logic                 req_q;
  logic                 ptw_active_q;
  logic                 store_q;
  mmu_pkg::vaddr_t      vaddr_q;
  mmu_pkg::tlb_lookup_t lookup_q;
  logic                 access_err;

  function automatic mmu_pkg::lsu_exception_t page_fault(input logic is_store,
                                                         input mmu_pkg::vaddr_t va);
    mmu_pkg::lsu_exception_t ex;
    ex.cause = is_store ? mmu_pkg::STORE_PAGE_FAULT : mmu_pkg::LOAD_PAGE_FAULT;
    ex.tval  = {{(64 - mmu_pkg::VLEN){1'b0}}, va};
    ex.valid = 1'b1;
    return ex;
  endfunction

  // bare mode is always ready
  assign dtlb_hit_o   = en_i ? lookup_i.hit : 1'b1;
  assign walk_vaddr_o = vaddr_q;

  // user page from S without SUM, or supervisor page from U
  assign access_err = ((priv_lvl_i == mmu_pkg::PRIV_S) && !sum_i && lookup_q.pte.u)
                   || ((priv_lvl_i == mmu_pkg::PRIV_U) && !lookup_q.pte.u);

  // --------------------
  // response
  // --------------------
  always_comb begin
    paddr_o     = {{(mmu_pkg::PLEN - mmu_pkg::VLEN){1'b0}}, vaddr_q};
    valid_o     = req_q;
    exception_o = '0;
    walk_req_o  = 1'b0;

    if (en_i) begin
      valid_o = 1'b0;
      paddr_o = {lookup_q.pte.ppn, vaddr_q[mmu_pkg::PAGE_OFFSET_W-1:0]};
      // superpages take the lower VPN slices from the vaddr
      if (lookup_q.is_2m) begin
        paddr_o[mmu_pkg::PAGE_OFFSET_W +: mmu_pkg::VPN_W] =
          vaddr_q[mmu_pkg::PAGE_OFFSET_W +: mmu_pkg::VPN_W];
      end
      if (lookup_q.is_1g) begin
        paddr_o[mmu_pkg::PAGE_OFFSET_W +: 2*mmu_pkg::VPN_W] =
          vaddr_q[mmu_pkg::PAGE_OFFSET_W +: 2*mmu_pkg::VPN_W];
      end

      if (req_q && lookup_q.hit) begin
        valid_o = 1'b1;
        if (store_q) begin
          if (!lookup_q.pte.w || !lookup_q.pte.d || access_err) begin
            exception_o = page_fault(1'b1, vaddr_q);
          end
        end else if (access_err) begin
          exception_o = page_fault(1'b0, vaddr_q);
        end
      end else if (req_q) begin
        // miss, ptw_active_q covers the cycle the refill becomes visible
        walk_req_o = !ptw_active_i && !ptw_active_q;
        if (ptw_error_i) begin
          valid_o     = 1'b1;
          exception_o = page_fault(store_q, walk_err_vaddr_i);
        end
      end
    end
  end

  // --------------------
  // request registers
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_q        <= 1'b0;
      ptw_active_q <= 1'b0;
    end else begin
      req_q        <= lsu_req_i;
      ptw_active_q <= ptw_active_i;
    end
  end

  // everything here is qualified by req_q
  always_ff @(posedge clk_i) begin
    vaddr_q  <= lsu_vaddr_i;
    store_q  <= lsu_is_store_i;
    lookup_q <= lookup_i;
  end

endmodule

// ==== design/mmu_pkg.sv ====
// Sv39 data MMU shared definitions
// address widths, PTE layout, TLB update and lookup structs,
// load/store exception record, cause codes and privilege levels

package mmu_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int unsigned VLEN          = 39;
  localparam int unsigned PLEN          = 56;
  localparam int unsigned PPNW          = 44;
  localparam int unsigned PAGE_OFFSET_W = 12;
  localparam int unsigned VPN_W         = 9;
  localparam int unsigned PT_LEVELS     = 3;
  localparam int unsigned PTE_BYTES     = 8;
  localparam int unsigned DTLB_ENTRIES  = 4;

  typedef logic [VLEN-1:0]            vaddr_t;
  typedef logic [PLEN-1:0]            paddr_t;
  typedef logic [PPNW-1:0]            ppn_t;
  typedef logic [PT_LEVELS*VPN_W-1:0] vpn_t;
  // table level index, 2 is the root
  typedef logic [$clog2(PT_LEVELS)-1:0] lvl_t;

  // Sv39 page table entry, v in bit 0
  typedef struct packed {
    logic [9:0] reserved;
    ppn_t       ppn;
    logic [1:0] rsw;
    logic       d;
    logic       a;
    logic       g;
    logic       u;
    logic       x;
    logic       w;
    logic       r;
    logic       v;
  } pte_t;

  // walker to TLB refill
  typedef struct packed {
    logic valid;
    logic is_2m;
    logic is_1g;
    vpn_t vpn;
    pte_t pte;
  } tlb_update_t;

  // TLB to translation stage
  typedef struct packed {
    logic hit;
    logic is_2m;
    logic is_1g;
    pte_t pte;
  } tlb_lookup_t;

  typedef struct packed {
    logic [63:0] cause;
    logic [63:0] tval;
    logic        valid;
  } lsu_exception_t;

  localparam logic [63:0] LOAD_PAGE_FAULT  = 64'd13;
  localparam logic [63:0] STORE_PAGE_FAULT = 64'd15;

  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } priv_lvl_t;

  typedef enum logic [1:0] {
    PTW_IDLE,
    PTW_READ,
    PTW_WAIT,
    PTW_DONE
  } ptw_state_t;

endpackage

// ==== design/mmu_top.sv ====
// Sv39 data MMU top level
// connects the data TLB, the page table walker and the
// load/store translation stage

`timescale 1ns/1ps

module mmu_top (
  input  logic                    clk_i,
  input  logic                    rst_i,
  // load/store request
  input  logic                    lsu_req_i,
  input  mmu_pkg::vaddr_t         lsu_vaddr_i,
  input  logic                    lsu_is_store_i,
  // control
  input  logic                    en_ld_st_translation_i,
  input  mmu_pkg::priv_lvl_t      ld_st_priv_lvl_i,
  input  logic                    sum_i,
  input  mmu_pkg::ppn_t           satp_ppn_i,
  input  logic                    flush_tlb_i,
  // results
  output logic                    lsu_dtlb_hit_o,
  output logic                    lsu_valid_o,
  output mmu_pkg::paddr_t         lsu_paddr_o,
  output mmu_pkg::lsu_exception_t lsu_exception_o,
  // page table memory
  output logic                    mem_req_o,
  output mmu_pkg::paddr_t         mem_addr_o,
  input  logic                    mem_rvalid_i,
  input  mmu_pkg::pte_t           mem_rdata_i
);

  logic                 walk_req;
  mmu_pkg::vaddr_t      walk_vaddr;
  logic                 ptw_active;
  logic                 ptw_error;
  mmu_pkg::vaddr_t      walk_err_vaddr;
  mmu_pkg::tlb_update_t tlb_update;
  mmu_pkg::tlb_lookup_t dtlb_lookup;

  dtlb i_dtlb (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .flush_i    (flush_tlb_i),
    .update_i   (tlb_update),
    .lu_vaddr_i (lsu_vaddr_i),
    .lu_o       (dtlb_lookup)
  );

  ptw i_ptw (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .flush_i          (flush_tlb_i),
    .satp_ppn_i       (satp_ppn_i),
    .walk_req_i       (walk_req),
    .walk_vaddr_i     (walk_vaddr),
    .ptw_active_o     (ptw_active),
    .ptw_error_o      (ptw_error),
    .walk_err_vaddr_o (walk_err_vaddr),
    .update_o         (tlb_update),
    .mem_req_o        (mem_req_o),
    .mem_addr_o       (mem_addr_o),
    .mem_rvalid_i     (mem_rvalid_i),
    .mem_rdata_i      (mem_rdata_i)
  );

  ld_st_translate i_ld_st_translate (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .lsu_req_i        (lsu_req_i),
    .lsu_vaddr_i      (lsu_vaddr_i),
    .lsu_is_store_i   (lsu_is_store_i),
    .en_i             (en_ld_st_translation_i),
    .priv_lvl_i       (ld_st_priv_lvl_i),
    .sum_i            (sum_i),
    .lookup_i         (dtlb_lookup),
    .ptw_active_i     (ptw_active),
    .ptw_error_i      (ptw_error),
    .walk_err_vaddr_i (walk_err_vaddr),
    .walk_req_o       (walk_req),
    .walk_vaddr_o     (walk_vaddr),
    .dtlb_hit_o       (lsu_dtlb_hit_o),
    .valid_o          (lsu_valid_o),
    .paddr_o          (lsu_paddr_o),
    .exception_o      (lsu_exception_o)
  );

endmodule

// ==== design/ptw.sv ====
// Sv39 page table walker
// walks up to three table levels through a single-outstanding
// memory read port, then refills the data TLB or flags a page fault

`timescale 1ns/1ps

module ptw (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 flush_i,
  input  mmu_pkg::ppn_t        satp_ppn_i,
  input  logic                 walk_req_i,
  input  mmu_pkg::vaddr_t      walk_vaddr_i,
  output logic                 ptw_active_o,
  output logic                 ptw_error_o,
  output mmu_pkg::vaddr_t      walk_err_vaddr_o,
  output mmu_pkg::tlb_update_t update_o,
  output logic                 mem_req_o,
  output mmu_pkg::paddr_t      mem_addr_o,
  input  logic                 mem_rvalid_i,
  input  mmu_pkg::pte_t        mem_rdata_i
);

  mmu_pkg::ptw_state_t state_q;
  mmu_pkg::vaddr_t     vaddr_q;
  mmu_pkg::ppn_t       ptr_q;
  mmu_pkg::pte_t       pte_q;
  mmu_pkg::lvl_t       lvl_q;
  logic                err_q;
  logic                flushed_q;

  logic [mmu_pkg::VPN_W-1:0] vpn_sel;
  logic                      is_leaf;
  logic                      misaligned;
  logic                      pte_fault;

  // VPN slice for the current level
  assign vpn_sel = vaddr_q[mmu_pkg::PAGE_OFFSET_W + lvl_q*mmu_pkg::VPN_W +: mmu_pkg::VPN_W];

  // pte address = table base * 4096 + vpn * 8
  assign mem_addr_o = {ptr_q, vpn_sel, {$clog2(mmu_pkg::PTE_BYTES){1'b0}}};
  assign mem_req_o  = (state_q == mmu_pkg::PTW_READ);

  // --------------------
  // PTE checks
  // --------------------
  assign is_leaf = mem_rdata_i.r || mem_rdata_i.x;

  // superpage leaves need their lower PPN slices clear
  always_comb begin
    misaligned = 1'b0;
    if (lvl_q == mmu_pkg::lvl_t'(2)) begin
      misaligned = |mem_rdata_i.ppn[2*mmu_pkg::VPN_W-1:0];
    end else if (lvl_q == mmu_pkg::lvl_t'(1)) begin
      misaligned = |mem_rdata_i.ppn[mmu_pkg::VPN_W-1:0];
    end
  end

  assign pte_fault = !mem_rdata_i.v
                  || (mem_rdata_i.w && !mem_rdata_i.r)
                  || (is_leaf && (!mem_rdata_i.a || misaligned))
                  || (!is_leaf && lvl_q == '0);

  // --------------------
  // walk FSM
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= mmu_pkg::PTW_IDLE;
      err_q     <= 1'b0;
      flushed_q <= 1'b0;
    end else begin
      // remember a flush so the stale result is not written back
      if (flush_i && state_q != mmu_pkg::PTW_IDLE) begin
        flushed_q <= 1'b1;
      end
      case (state_q)
        mmu_pkg::PTW_IDLE: begin
          if (walk_req_i) begin
            state_q   <= mmu_pkg::PTW_READ;
            err_q     <= 1'b0;
            flushed_q <= 1'b0;
          end
        end
        mmu_pkg::PTW_READ: begin
          state_q <= mmu_pkg::PTW_WAIT;
        end
        mmu_pkg::PTW_WAIT: begin
          if (mem_rvalid_i) begin
            if (pte_fault) begin
              err_q   <= 1'b1;
              state_q <= mmu_pkg::PTW_DONE;
            end else if (is_leaf) begin
              state_q <= mmu_pkg::PTW_DONE;
            end else begin
              // pointer, descend one level
              state_q <= mmu_pkg::PTW_READ;
            end
          end
        end
        mmu_pkg::PTW_DONE: begin
          state_q <= mmu_pkg::PTW_IDLE;
        end
        default: begin
          state_q <= mmu_pkg::PTW_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == mmu_pkg::PTW_IDLE && walk_req_i) begin
      vaddr_q <= walk_vaddr_i;
      ptr_q   <= satp_ppn_i;
      lvl_q   <= mmu_pkg::lvl_t'(mmu_pkg::PT_LEVELS - 1);
    end else if (state_q == mmu_pkg::PTW_WAIT && mem_rvalid_i) begin
      pte_q <= mem_rdata_i;
      if (!is_leaf && !pte_fault) begin
        ptr_q <= mem_rdata_i.ppn;
        lvl_q <= lvl_q - 1'b1;
      end
    end
  end

  // --------------------
  // results
  // --------------------
  assign ptw_active_o     = (state_q != mmu_pkg::PTW_IDLE);
  assign ptw_error_o      = (state_q == mmu_pkg::PTW_DONE) && err_q;
  assign walk_err_vaddr_o = vaddr_q;

  // leaf level tells the page size
  always_comb begin
    update_o.valid = (state_q == mmu_pkg::PTW_DONE) && !err_q && !flushed_q;
    update_o.is_2m = (lvl_q == mmu_pkg::lvl_t'(1));
    update_o.is_1g = (lvl_q == mmu_pkg::lvl_t'(2));
    update_o.vpn   = vaddr_q[mmu_pkg::VLEN-1:mmu_pkg::PAGE_OFFSET_W];
    update_o.pte   = pte_q;
  end

endmodule

// ==== list.f ====
design/mmu_pkg.sv
design/dtlb.sv
design/ptw.sv
design/ld_st_translate.sv
design/mmu_top.sv
tests/page_table_model.sv
tests/tb_mmu.sv

// ==== tests/page_table_model.sv ====
// Page table memory model
// sparse store of 64-bit PTEs filled through a write port,
// answers each walker read once, 1 to 4 cycles after the request

`timescale 1ns/1ps

module page_table_model #(
  parameter int unsigned SEED = 1
) (
  input  logic            clk_i,
  input  logic            wr_en_i,
  input  mmu_pkg::paddr_t wr_addr_i,
  input  mmu_pkg::pte_t   wr_data_i,
  input  logic            mem_req_i,
  input  mmu_pkg::paddr_t mem_addr_i,
  output logic            mem_rvalid_o,
  output mmu_pkg::pte_t   mem_rdata_o
);

  mmu_pkg::pte_t pte_mem [mmu_pkg::paddr_t];

  // table setup, done before any walk starts
  always @(posedge clk_i) begin
    if (wr_en_i) begin
      pte_mem[wr_addr_i] = wr_data_i;
    end
  end

  // --------------------
  // read responder
  // --------------------
  // one read outstanding at a time, so a single sequential process is enough
  initial begin
    int unsigned     latency;
    mmu_pkg::paddr_t addr;
    mem_rvalid_o <= 1'b0;
    mem_rdata_o  <= '0;
    void'($urandom(SEED));
    forever begin
      @(posedge clk_i);
      if (mem_req_i) begin
        addr    = mem_addr_i;
        latency = 1 + ($urandom % 4);
        repeat (latency - 1) @(posedge clk_i);
        mem_rvalid_o <= 1'b1;
        // unmapped entries read as an invalid PTE
        if (pte_mem.exists(addr)) begin
          mem_rdata_o <= pte_mem[addr];
        end else begin
          mem_rdata_o <= '0;
        end
        @(posedge clk_i);
        mem_rvalid_o <= 1'b0;
      end
    end
  end

endmodule

// ==== tests/tb_mmu.sv ====
// Testbench for the Sv39 data MMU
// builds a small page table in the memory model, then runs bare,
// refill, superpage, privilege, walk fault and flush accesses
// checked by concurrent and immediate assertions

`timescale 1ns/1ps

module tb_mmu;

  localparam int unsigned SEED    = 91905;
  localparam int          TIMEOUT = 60;

  // root table and the two lower tables behind vpn2 = 1
  localparam mmu_pkg::ppn_t ROOT_PPN = 44'h80000;
  localparam mmu_pkg::ppn_t L1_PPN   = 44'h80001;
  localparam mmu_pkg::ppn_t L0_PPN   = 44'h80002;

  // flag byte {d, a, g, u, x, w, r, v}
  localparam logic [7:0] PTR    = 8'h01;
  localparam logic [7:0] RW_S   = 8'hc7;
  localparam logic [7:0] RW_U   = 8'hd7;
  localparam logic [7:0] RO_S   = 8'hc3;
  localparam logic [7:0] RW_NOD = 8'h47;
  localparam logic [7:0] RW_NOA = 8'h87;

  localparam mmu_pkg::ppn_t PPN_S4K   = 44'h11111;
  localparam mmu_pkg::ppn_t PPN_U4K   = 44'h22222;
  localparam mmu_pkg::ppn_t PPN_RO    = 44'h33333;
  localparam mmu_pkg::ppn_t PPN_NOD   = 44'h44444;
  localparam mmu_pkg::ppn_t PPN_2M    = 44'ha0200;
  localparam mmu_pkg::ppn_t PPN_BAD2M = 44'ha0201;
  localparam mmu_pkg::ppn_t PPN_1G    = 44'hc0000;

  // virtual addresses as {vpn2, vpn1, vpn0, offset}
  localparam mmu_pkg::vaddr_t VA_BARE0 = 39'h12_3456_789a;
  localparam mmu_pkg::vaddr_t VA_BARE1 = 39'h7f_0000_0ff8;
  localparam mmu_pkg::vaddr_t VA_S4K   = {9'd1, 9'd2, 9'd0, 12'h123};
  localparam mmu_pkg::vaddr_t VA_U4K   = {9'd1, 9'd2, 9'd1, 12'h2a8};
  localparam mmu_pkg::vaddr_t VA_RO    = {9'd1, 9'd2, 9'd2, 12'h010};
  localparam mmu_pkg::vaddr_t VA_NOD   = {9'd1, 9'd2, 9'd3, 12'h7f8};
  localparam mmu_pkg::vaddr_t VA_INV   = {9'd1, 9'd2, 9'd4, 12'h000};
  localparam mmu_pkg::vaddr_t VA_NOA   = {9'd1, 9'd2, 9'd5, 12'h444};
  localparam mmu_pkg::vaddr_t VA_2M    = {9'd1, 9'd3, 9'h1ab, 12'h456};
  localparam mmu_pkg::vaddr_t VA_2M_B  = {9'd1, 9'd3, 9'h003, 12'hff0};
  localparam mmu_pkg::vaddr_t VA_BAD2M = {9'd1, 9'd4, 9'h0f0, 12'h008};
  localparam mmu_pkg::vaddr_t VA_1G    = {9'd2, 9'h055, 9'h077, 12'h9ab};

  logic                    clk = 1'b0;
  logic                    rst;
  logic                    lsu_req;
  mmu_pkg::vaddr_t         lsu_vaddr;
  logic                    lsu_is_store;
  logic                    en_translation;
  mmu_pkg::priv_lvl_t      priv_lvl;
  logic                    sum;
  mmu_pkg::ppn_t           satp_ppn;
  logic                    flush_tlb;
  logic                    lsu_dtlb_hit;
  logic                    lsu_valid;
  mmu_pkg::paddr_t         lsu_paddr;
  mmu_pkg::lsu_exception_t lsu_exception;
  logic                    mem_req;
  mmu_pkg::paddr_t         mem_addr;
  logic                    mem_rvalid;
  mmu_pkg::pte_t           mem_rdata;
  logic                    pt_wr_en;
  mmu_pkg::paddr_t         pt_wr_addr;
  mmu_pkg::pte_t           pt_wr_data;
  int                      mem_reads;

  always #20 clk = ~clk;

  mmu_top dut (
    .clk_i                  (clk),
    .rst_i                  (rst),
    .lsu_req_i              (lsu_req),
    .lsu_vaddr_i            (lsu_vaddr),
    .lsu_is_store_i         (lsu_is_store),
    .en_ld_st_translation_i (en_translation),
    .ld_st_priv_lvl_i       (priv_lvl),
    .sum_i                  (sum),
    .satp_ppn_i             (satp_ppn),
    .flush_tlb_i            (flush_tlb),
    .lsu_dtlb_hit_o         (lsu_dtlb_hit),
    .lsu_valid_o            (lsu_valid),
    .lsu_paddr_o            (lsu_paddr),
    .lsu_exception_o        (lsu_exception),
    .mem_req_o              (mem_req),
    .mem_addr_o             (mem_addr),
    .mem_rvalid_i           (mem_rvalid),
    .mem_rdata_i            (mem_rdata)
  );

  page_table_model #(.SEED(SEED)) pt_model (
    .clk_i        (clk),
    .wr_en_i      (pt_wr_en),
    .wr_addr_i    (pt_wr_addr),
    .wr_data_i    (pt_wr_data),
    .mem_req_i    (mem_req),
    .mem_addr_i   (mem_addr),
    .mem_rvalid_o (mem_rvalid),
    .mem_rdata_o  (mem_rdata)
  );

  always @(posedge clk) begin
    if (rst) begin
      mem_reads <= 0;
    end else if (mem_req) begin
      mem_reads <= mem_reads + 1;
    end
  end

  // --------------------
  // helpers
  // --------------------
  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_eq(input string name, input string what,
                          input logic [63:0] expected, input logic [63:0] actual);
    assert (expected == actual)
      else stop_with_error($sformatf("[FAIL] %s %s: expected 0x%0h, actual 0x%0h",
                                     name, what, expected, actual));
  endtask

  function automatic mmu_pkg::pte_t make_pte(input mmu_pkg::ppn_t ppn,
                                             input logic [7:0] flags);
    return mmu_pkg::pte_t'({10'b0, ppn, 2'b00, flags});
  endfunction

  // one 8 byte PTE per vpn value inside a 4K table
  function automatic mmu_pkg::paddr_t entry_addr(input mmu_pkg::ppn_t table_ppn,
                                                 input logic [8:0] vpn);
    return {table_ppn, vpn, 3'b000};
  endfunction

  // page base from the leaf, the rest from the vaddr; level 0 is 4K
  function automatic mmu_pkg::paddr_t leaf_paddr(input mmu_pkg::ppn_t ppn,
                                                 input mmu_pkg::vaddr_t va, input int level);
    mmu_pkg::paddr_t mask;
    mask = (mmu_pkg::paddr_t'(1) << (12 + 9 * level)) - mmu_pkg::paddr_t'(1);
    return ({ppn, 12'h000} & ~mask) | (mmu_pkg::paddr_t'(va) & mask);
  endfunction

  task automatic write_pte(input mmu_pkg::paddr_t addr, input mmu_pkg::pte_t pte);
    @(negedge clk);
    pt_wr_en   = 1'b1;
    pt_wr_addr = addr;
    pt_wr_data = pte;
    @(negedge clk);
    pt_wr_en = 1'b0;
  endtask

  task automatic pulse_flush();
    @(negedge clk);
    flush_tlb = 1'b1;
    @(negedge clk);
    flush_tlb = 1'b0;
  endtask

  // hold one request until lsu_valid, then check the response
  task automatic access(input string name, input mmu_pkg::vaddr_t va, input logic is_store,
                        input logic expect_hit, input logic exp_fault,
                        input mmu_pkg::paddr_t exp_paddr);
    int   cycles;
    int   reads_before;
    logic hit_seen;
    @(negedge clk);
    lsu_req      = 1'b1;
    lsu_vaddr    = va;
    lsu_is_store = is_store;
    reads_before = mem_reads;
    #1;
    hit_seen = lsu_dtlb_hit;
    cycles   = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        stop_with_error($sformatf("%s: no lsu_valid_o within %0d cycles", name, TIMEOUT));
      end
    end while (!lsu_valid);
    lsu_req = 1'b0;
    check_eq(name, "dtlb hit", 64'(expect_hit), 64'(hit_seen));
    if (expect_hit) begin
      check_eq(name, "latency", 64'd1, 64'(cycles));
      check_eq(name, "memory reads", 64'(reads_before), 64'(mem_reads));
    end else begin
      assert (mem_reads > reads_before)
        else stop_with_error($sformatf("%s: a TLB miss ended without a memory read", name));
    end
    check_eq(name, "fault", 64'(exp_fault), 64'(lsu_exception.valid));
    if (exp_fault) begin
      check_eq(name, "cause",
               is_store ? mmu_pkg::STORE_PAGE_FAULT : mmu_pkg::LOAD_PAGE_FAULT,
               lsu_exception.cause);
      check_eq(name, "tval", 64'(va), lsu_exception.tval);
    end else begin
      check_eq(name, "paddr", 64'(exp_paddr), 64'(lsu_paddr));
    end
  endtask

  // --------------------
  // protocol checks
  // --------------------
  assert property (@(posedge clk) disable iff (rst) mem_req |=> !mem_req)
    else stop_with_error("mem_req_o stayed high for more than one cycle");

  assert property (@(posedge clk) disable iff (rst)
                   (lsu_req && !en_translation) |-> lsu_dtlb_hit)
    else stop_with_error("bare mode request without lsu_dtlb_hit_o");

  assert property (@(posedge clk) disable iff (rst)
                   (lsu_req && lsu_dtlb_hit && !lsu_valid) |=> lsu_valid)
    else stop_with_error("lsu_valid_o did not follow a hit one cycle later");

  assert property (@(posedge clk) disable iff (rst)
                   (lsu_req && en_translation && lsu_dtlb_hit) |-> !mem_req)
    else stop_with_error("memory read issued during a TLB hit");

  assert property (@(posedge clk) disable iff (rst)
                   (lsu_valid && !en_translation) |-> !lsu_exception.valid)
    else stop_with_error("exception raised in bare mode");

  // --------------------
  // stimulus
  // --------------------
  initial begin
    rst            = 1'b1;
    lsu_req        = 1'b0;
    lsu_vaddr      = '0;
    lsu_is_store   = 1'b0;
    en_translation = 1'b0;
    priv_lvl       = mmu_pkg::PRIV_S;
    sum            = 1'b0;
    satp_ppn       = ROOT_PPN;
    flush_tlb      = 1'b0;
    pt_wr_en       = 1'b0;
    pt_wr_addr     = '0;
    pt_wr_data     = '0;
    repeat (3) @(negedge clk);
    rst = 1'b0;

    // L0 entry 4 stays unwritten and reads back invalid
    write_pte(entry_addr(ROOT_PPN, 9'd1), make_pte(L1_PPN, PTR));
    write_pte(entry_addr(ROOT_PPN, 9'd2), make_pte(PPN_1G, RW_S));
    write_pte(entry_addr(L1_PPN, 9'd2), make_pte(L0_PPN, PTR));
    write_pte(entry_addr(L1_PPN, 9'd3), make_pte(PPN_2M, RW_S));
    write_pte(entry_addr(L1_PPN, 9'd4), make_pte(PPN_BAD2M, RW_S));
    write_pte(entry_addr(L0_PPN, 9'd0), make_pte(PPN_S4K, RW_S));
    write_pte(entry_addr(L0_PPN, 9'd1), make_pte(PPN_U4K, RW_U));
    write_pte(entry_addr(L0_PPN, 9'd2), make_pte(PPN_RO, RO_S));
    write_pte(entry_addr(L0_PPN, 9'd3), make_pte(PPN_NOD, RW_NOD));
    write_pte(entry_addr(L0_PPN, 9'd5), make_pte(44'h55555, RW_NOA));

    access("bare_load", VA_BARE0, 1'b0, 1'b1, 1'b0, mmu_pkg::paddr_t'(VA_BARE0));
    access("bare_store", VA_BARE1, 1'b1, 1'b1, 1'b0, mmu_pkg::paddr_t'(VA_BARE1));

    // the last bare request leaves the registered stage first
    @(negedge clk);
    // TLB fills slots 0 to 3 in order with 4K S, 2M, 1G and 4K U
    en_translation = 1'b1;
    access("refill_4k", VA_S4K, 1'b0, 1'b0, 1'b0, leaf_paddr(PPN_S4K, VA_S4K, 0));
    access("hit_4k", VA_S4K, 1'b0, 1'b1, 1'b0, leaf_paddr(PPN_S4K, VA_S4K, 0));
    access("store_4k", VA_S4K, 1'b1, 1'b1, 1'b0, leaf_paddr(PPN_S4K, VA_S4K, 0));
    access("refill_2m", VA_2M, 1'b0, 1'b0, 1'b0, leaf_paddr(PPN_2M, VA_2M, 1));
    access("hit_2m", VA_2M_B, 1'b0, 1'b1, 1'b0, leaf_paddr(PPN_2M, VA_2M_B, 1));
    access("refill_1g", VA_1G, 1'b0, 1'b0, 1'b0, leaf_paddr(PPN_1G, VA_1G, 2));

    access("s_user_load", VA_U4K, 1'b0, 1'b0, 1'b1, '0);
    sum = 1'b1;
    access("s_user_sum", VA_U4K, 1'b0, 1'b1, 1'b0, leaf_paddr(PPN_U4K, VA_U4K, 0));
    priv_lvl = mmu_pkg::PRIV_U;
    access("u_user_load", VA_U4K, 1'b0, 1'b1, 1'b0, leaf_paddr(PPN_U4K, VA_U4K, 0));
    access("u_super_load", VA_S4K, 1'b0, 1'b1, 1'b1, '0);
    priv_lvl = mmu_pkg::PRIV_S;
    sum      = 1'b0;

    // these refills replace slots 0 and 1
    access("store_no_w", VA_RO, 1'b1, 1'b0, 1'b1, '0);
    access("store_no_d", VA_NOD, 1'b1, 1'b0, 1'b1, '0);

    access("walk_invalid", VA_INV, 1'b0, 1'b0, 1'b1, '0);
    access("walk_misaligned", VA_BAD2M, 1'b1, 1'b0, 1'b1, '0);
    access("walk_no_a", VA_NOA, 1'b0, 1'b0, 1'b1, '0);

    access("before_flush", VA_1G, 1'b0, 1'b1, 1'b0, leaf_paddr(PPN_1G, VA_1G, 2));
    pulse_flush();
    access("after_flush", VA_1G, 1'b0, 1'b0, 1'b0, leaf_paddr(PPN_1G, VA_1G, 2));

    repeat (2) @(negedge clk);
    $display("Test OK");
    $finish;
  end

endmodule
